//--- verilog/fetchPkg.sv
// sizes and encodings shared by the fetch stage 1 front end
// all addresses are byte addresses; bundles and cache lines are 16 bytes and aligned
`default_nettype none

package fetchPkg;

  // basic widths
  localparam int PC_WIDTH = 32;
  localparam int INST_WIDTH = 32;
  localparam int FETCH_WIDTH = 4;
  localparam logic [PC_WIDTH-1:0] INST_BYTES = 4;
  // pc step when nothing in the bundle is taken
  localparam logic [PC_WIDTH-1:0] BUNDLE_BYTES = FETCH_WIDTH * INST_BYTES;
  // one bundle is also one cache line
  localparam int BUNDLE_WIDTH = FETCH_WIDTH * INST_WIDTH;

  // pc field positions: slot in bits 3:2, indexes start at bit 4
  localparam int SLOT_LSB = $clog2(INST_BYTES);
  localparam int SLOT_WIDTH = $clog2(FETCH_WIDTH);
  localparam int OFFSET_WIDTH = $clog2(BUNDLE_BYTES);

  // instruction cache
  localparam int ICACHE_LINES = 64;
  localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_LINES);
  localparam int ICACHE_TAG_WIDTH = PC_WIDTH - ICACHE_INDEX_WIDTH - OFFSET_WIDTH;

  // branch target buffer, one bank per slot
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_INDEX_WIDTH = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_WIDTH = PC_WIDTH - BTB_INDEX_WIDTH - OFFSET_WIDTH;

  // direction predictor, one bank per slot
  localparam int BP_ENTRIES = 64;
  localparam int BP_INDEX_WIDTH = $clog2(BP_ENTRIES);

  // return address stack
  localparam int RAS_DEPTH = 8;
  localparam int RAS_PTR_WIDTH = $clog2(RAS_DEPTH);

  // two-bit counter reset value and taken threshold
  localparam logic [1:0] CNT_WEAK_NT = 2'd1;
  localparam logic [1:0] CNT_TAKEN_MIN = 2'd2;

  // kind of control instruction held in the BTB
  typedef enum logic [1:0] {
    BR_RETURN = 2'd0,
    BR_CALL   = 2'd1,
    BR_JUMP   = 2'd2,
    BR_COND   = 2'd3
  } brType_e;

endpackage

`default_nettype wire

//--- verilog/branchTargetBuffer.sv
// four-bank BTB, bank n holds slot n of every bundle
// lookup is combinational from pc_i; the caller filters updates by type
`timescale 1ns/1ns
`default_nettype none

module branchTargetBuffer (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [fetchPkg::PC_WIDTH-1:0]          pc_i,
  input  logic                                   updateEn_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]          updatePC_i,
  input  fetchPkg::brType_e                      updateBrType_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]          updateTargetAddr_i,
  output logic [fetchPkg::FETCH_WIDTH-1:0]       btbHit_o,
  output fetchPkg::brType_e [fetchPkg::FETCH_WIDTH-1:0] ctrlType_o,
  output logic [fetchPkg::FETCH_WIDTH-1:0][fetchPkg::PC_WIDTH-1:0] targetAddr_o
);

  // per-bank valid bits, cleared by reset
  logic [fetchPkg::BTB_ENTRIES-1:0] validBits [fetchPkg::FETCH_WIDTH];
  // payload arrays
  logic [fetchPkg::BTB_TAG_WIDTH-1:0] tagArray [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];
  fetchPkg::brType_e typeArray [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];
  logic [fetchPkg::PC_WIDTH-1:0] targetArray [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];

  logic [fetchPkg::BTB_INDEX_WIDTH-1:0] rdIndex;
  logic [fetchPkg::BTB_INDEX_WIDTH-1:0] wrIndex;
  logic [fetchPkg::BTB_TAG_WIDTH-1:0]   rdTag;
  logic [fetchPkg::BTB_TAG_WIDTH-1:0]   wrTag;
  logic [fetchPkg::SLOT_WIDTH-1:0]      wrSlot;

  // lookup fields of the fetch pc
  assign rdIndex = pc_i[fetchPkg::OFFSET_WIDTH +: fetchPkg::BTB_INDEX_WIDTH];
  assign rdTag   = pc_i[fetchPkg::PC_WIDTH-1 -: fetchPkg::BTB_TAG_WIDTH];
  // update fields, the slot picks the bank
  assign wrIndex = updatePC_i[fetchPkg::OFFSET_WIDTH +: fetchPkg::BTB_INDEX_WIDTH];
  assign wrTag   = updatePC_i[fetchPkg::PC_WIDTH-1 -: fetchPkg::BTB_TAG_WIDTH];
  assign wrSlot  = updatePC_i[fetchPkg::SLOT_LSB +: fetchPkg::SLOT_WIDTH];

  // all banks read at the same bundle index
  always_comb begin
    for (int s = 0; s < fetchPkg::FETCH_WIDTH; s++) begin
      btbHit_o[s]     = validBits[s][rdIndex] && (tagArray[s][rdIndex] == rdTag);
      ctrlType_o[s]   = typeArray[s][rdIndex];
      targetAddr_o[s] = targetArray[s][rdIndex];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < fetchPkg::FETCH_WIDTH; s++) begin
        validBits[s] <= '0;
      end
    end else if (updateEn_i) begin
      validBits[wrSlot][wrIndex] <= 1'b1;
    end
  end

  // a new entry simply replaces whatever sat at that index
  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      tagArray[wrSlot][wrIndex]    <= wrTag;
      typeArray[wrSlot][wrIndex]   <= updateBrType_i;
      targetArray[wrSlot][wrIndex] <= updateTargetAddr_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/branchPredictor.sv
// four banks of two-bit saturating counters, no history
// updates are expected only for conditional branches
`timescale 1ns/1ns
`default_nettype none

module branchPredictor (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [fetchPkg::PC_WIDTH-1:0]    pc_i,
  input  logic                             updateEn_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]    updatePC_i,
  input  logic                             updateDir_i,
  output logic [fetchPkg::FETCH_WIDTH-1:0] prediction_o
);

  logic [1:0] counter [fetchPkg::FETCH_WIDTH][fetchPkg::BP_ENTRIES];

  logic [fetchPkg::BP_INDEX_WIDTH-1:0] rdIndex;
  logic [fetchPkg::BP_INDEX_WIDTH-1:0] wrIndex;
  logic [fetchPkg::SLOT_WIDTH-1:0]     wrSlot;
  logic [1:0]                          curCount;

  assign rdIndex  = pc_i[fetchPkg::OFFSET_WIDTH +: fetchPkg::BP_INDEX_WIDTH];
  assign wrIndex  = updatePC_i[fetchPkg::OFFSET_WIDTH +: fetchPkg::BP_INDEX_WIDTH];
  assign wrSlot   = updatePC_i[fetchPkg::SLOT_LSB +: fetchPkg::SLOT_WIDTH];
  // counter being trained this cycle
  assign curCount = counter[wrSlot][wrIndex];

  // upper half of the counter range predicts taken
  always_comb begin
    for (int s = 0; s < fetchPkg::FETCH_WIDTH; s++) begin
      prediction_o[s] = counter[s][rdIndex] >= fetchPkg::CNT_TAKEN_MIN;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < fetchPkg::FETCH_WIDTH; s++) begin
        for (int e = 0; e < fetchPkg::BP_ENTRIES; e++) begin
          counter[s][e] <= fetchPkg::CNT_WEAK_NT;
        end
      end
    end else if (updateEn_i) begin
      // saturate at 3 and at 0
      if (updateDir_i && (curCount != 2'd3)) begin
        counter[wrSlot][wrIndex] <= curCount + 2'd1;
      end else if (!updateDir_i && (curCount != 2'd0)) begin
        counter[wrSlot][wrIndex] <= curCount - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/returnAddrStack.sv
// circular return address stack; overflow silently overwrites the oldest entry
// a decode correction wins over the fetch push/pop of the same cycle
`timescale 1ns/1ns
`default_nettype none

module returnAddrStack (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          stall_i,
  input  logic                          push_i,
  input  logic [fetchPkg::PC_WIDTH-1:0] pushAddr_i,
  input  logic                          pop_i,
  input  logic                          flagRecoverID_i,
  input  logic                          flagCallID_i,
  input  logic [fetchPkg::PC_WIDTH-1:0] callPCID_i,
  input  logic                          flagRtrID_i,
  output logic [fetchPkg::PC_WIDTH-1:0] addrRAS_o
);

  logic [fetchPkg::PC_WIDTH-1:0]      stack [fetchPkg::RAS_DEPTH];
  logic [fetchPkg::RAS_PTR_WIDTH-1:0] topPtr;
  logic [fetchPkg::RAS_PTR_WIDTH-1:0] pushPtr;
  logic                               idFix;
  logic                               doPush;
  logic                               doPop;
  logic [fetchPkg::PC_WIDTH-1:0]      pushData;

  // decode correction only lands when the pipe moves
  assign idFix   = flagRecoverID_i && !stall_i;
  assign pushPtr = topPtr + 1'b1;

  always_comb begin
    if (idFix) begin
      // call missed by the BTB pushes; a missed return pops
      doPush   = flagCallID_i;
      doPop    = flagRtrID_i && !flagCallID_i;
      pushData = callPCID_i;
    end else begin
      doPush   = push_i;
      doPop    = pop_i;
      pushData = pushAddr_i;
    end
  end

  // top of stack is visible in the lookup cycle
  assign addrRAS_o = stack[topPtr];

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      for (int i = 0; i < fetchPkg::RAS_DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else if (doPush) begin
      topPtr         <= pushPtr;
      stack[pushPtr] <= pushData;
    end else if (doPop) begin
      topPtr <= topPtr - 1'b1;
    end
  end

  // the fetch side finds one first taken slot, so it is a call or a return
  pushPopExclusive: assert property (@(posedge clk) disable iff (reset)
    !(push_i && pop_i));

endmodule

`default_nettype wire

//--- verilog/instCache.sv
// direct-mapped L1 instruction cache, one aligned bundle per line
// refill arrives as a whole line; lookup is combinational
`timescale 1ns/1ns
`default_nettype none

module instCache (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [fetchPkg::PC_WIDTH-1:0]     addr_i,
  input  logic                              wrEnable_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     wrAddr_i,
  input  logic [fetchPkg::BUNDLE_WIDTH-1:0] instBlock_i,
  output logic [fetchPkg::BUNDLE_WIDTH-1:0] instBundle_o,
  output logic                              miss_o,
  output logic [fetchPkg::PC_WIDTH-1:0]     missAddr_o
);

  logic [fetchPkg::ICACHE_LINES-1:0]     validBits;
  logic [fetchPkg::ICACHE_TAG_WIDTH-1:0] tagArray  [fetchPkg::ICACHE_LINES];
  logic [fetchPkg::BUNDLE_WIDTH-1:0]     dataArray [fetchPkg::ICACHE_LINES];

  logic [fetchPkg::ICACHE_INDEX_WIDTH-1:0] rdIndex;
  logic [fetchPkg::ICACHE_INDEX_WIDTH-1:0] wrIndex;
  logic [fetchPkg::ICACHE_TAG_WIDTH-1:0]   rdTag;
  logic [fetchPkg::ICACHE_TAG_WIDTH-1:0]   wrTag;

  assign rdIndex = addr_i[fetchPkg::OFFSET_WIDTH +: fetchPkg::ICACHE_INDEX_WIDTH];
  assign rdTag   = addr_i[fetchPkg::PC_WIDTH-1 -: fetchPkg::ICACHE_TAG_WIDTH];
  assign wrIndex = wrAddr_i[fetchPkg::OFFSET_WIDTH +: fetchPkg::ICACHE_INDEX_WIDTH];
  assign wrTag   = wrAddr_i[fetchPkg::PC_WIDTH-1 -: fetchPkg::ICACHE_TAG_WIDTH];

  // read side
  assign instBundle_o = dataArray[rdIndex];
  assign miss_o       = !(validBits[rdIndex] && (tagArray[rdIndex] == rdTag));
  // line the lower level has to send back
  assign missAddr_o   = {addr_i[fetchPkg::PC_WIDTH-1:fetchPkg::OFFSET_WIDTH],
                         {fetchPkg::OFFSET_WIDTH{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
    end else if (wrEnable_i) begin
      validBits[wrIndex] <= 1'b1;
    end
  end

  // refill writes tag and data at the edge, hit follows next cycle
  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      tagArray[wrIndex]  <= wrTag;
      dataArray[wrIndex] <= instBlock_i;
    end
  end

  refillAligned: assert property (@(posedge clk) disable iff (reset)
    wrEnable_i |-> (wrAddr_i[fetchPkg::OFFSET_WIDTH-1:0] == '0));

endmodule

`default_nettype wire

//--- verilog/fetchStage1.sv
// fetch stage 1 of a four-wide front end with PC, cache, BTB, predictor and RAS
// all redirect targets must be bundle aligned; inputs are plain strobes and levels
`timescale 1ns/1ns
`default_nettype none

module fetchStage1 (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              stall_i,
  // redirects, highest priority first
  input  logic                              recoverFlag_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     recoverPC_i,
  input  logic                              flagRecoverEX_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     targetAddrEX_i,
  input  logic                              flagRecoverID_i,
  input  logic                              flagCallID_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     callPCID_i,
  input  logic                              flagRtrID_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     targetAddrID_i,
  // in-order predictor and BTB training
  input  logic                              updateEn_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     updatePC_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     updateTargetAddr_i,
  input  fetchPkg::brType_e                 updateBrType_i,
  input  logic                              updateDir_i,
  // line refill from the lower level
  input  logic                              wrEnable_i,
  input  logic [fetchPkg::PC_WIDTH-1:0]     wrAddr_i,
  input  logic [fetchPkg::BUNDLE_WIDTH-1:0] instBlock_i,
  output logic [fetchPkg::PC_WIDTH-1:0]     pc_o,
  output logic [fetchPkg::BUNDLE_WIDTH-1:0] instructionBundle_o,
  output logic                              fs1Ready_o,
  output logic                              miss_o,
  output logic [fetchPkg::PC_WIDTH-1:0]     missAddr_o,
  output logic [fetchPkg::FETCH_WIDTH-1:0]  btbHit_o,
  output logic [fetchPkg::FETCH_WIDTH-1:0]  prediction_o,
  output logic [fetchPkg::FETCH_WIDTH-1:0][fetchPkg::PC_WIDTH-1:0] targetAddr_o
);

  logic [fetchPkg::PC_WIDTH-1:0]                             pcReg;
  logic [fetchPkg::PC_WIDTH-1:0]                             nextPc;
  logic [fetchPkg::FETCH_WIDTH-1:0]                          btbHit;
  logic [fetchPkg::FETCH_WIDTH-1:0]                          prediction;
  logic [fetchPkg::FETCH_WIDTH-1:0]                          slotTaken;
  fetchPkg::brType_e [fetchPkg::FETCH_WIDTH-1:0]             ctrlType;
  logic [fetchPkg::FETCH_WIDTH-1:0][fetchPkg::PC_WIDTH-1:0]  btbTarget;
  logic [fetchPkg::FETCH_WIDTH-1:0][fetchPkg::PC_WIDTH-1:0]  slotTarget;
  logic [fetchPkg::PC_WIDTH-1:0]                             addrRas;
  logic                                                      miss;
  logic                                                      updateBtb;
  logic                                                      updateBp;
  logic                                                      anyTaken;
  logic [fetchPkg::SLOT_WIDTH-1:0]                           firstSlot;
  logic [fetchPkg::PC_WIDTH-1:0]                             slotAddr;
  logic                                                      fetchAdvance;
  logic                                                      rasPush;
  logic                                                      rasPop;
  logic [fetchPkg::PC_WIDTH-1:0]                             rasPushAddr;

  // counters learn only from conditional branches
  assign updateBp  = updateEn_i && (updateBrType_i == fetchPkg::BR_COND);
  // not-taken conditionals never enter the BTB
  assign updateBtb = updateEn_i && ((updateBrType_i != fetchPkg::BR_COND) || updateDir_i);

  branchTargetBuffer branchTargetBuffer_i (
    .clk                (clk),
    .reset              (reset),
    .pc_i               (pcReg),
    .updateEn_i         (updateBtb),
    .updatePC_i         (updatePC_i),
    .updateBrType_i     (updateBrType_i),
    .updateTargetAddr_i (updateTargetAddr_i),
    .btbHit_o           (btbHit),
    .ctrlType_o         (ctrlType),
    .targetAddr_o       (btbTarget)
  );

  branchPredictor branchPredictor_i (
    .clk          (clk),
    .reset        (reset),
    .pc_i         (pcReg),
    .updateEn_i   (updateBp),
    .updatePC_i   (updatePC_i),
    .updateDir_i  (updateDir_i),
    .prediction_o (prediction)
  );

  returnAddrStack returnAddrStack_i (
    .clk             (clk),
    .reset           (reset),
    .stall_i         (stall_i),
    .push_i          (rasPush),
    .pushAddr_i      (rasPushAddr),
    .pop_i           (rasPop),
    .flagRecoverID_i (flagRecoverID_i),
    .flagCallID_i    (flagCallID_i),
    .callPCID_i      (callPCID_i),
    .flagRtrID_i     (flagRtrID_i),
    .addrRAS_o       (addrRas)
  );

  instCache instCache_i (
    .clk          (clk),
    .reset        (reset),
    .addr_i       (pcReg),
    .wrEnable_i   (wrEnable_i),
    .wrAddr_i     (wrAddr_i),
    .instBlock_i  (instBlock_i),
    .instBundle_o (instructionBundle_o),
    .miss_o       (miss),
    .missAddr_o   (missAddr_o)
  );

  // slot qualification and first taken slot
  // scanning downward leaves the lowest taken slot in firstSlot
  always_comb begin
    anyTaken  = 1'b0;
    firstSlot = '0;
    for (int s = fetchPkg::FETCH_WIDTH - 1; s >= 0; s--) begin
      slotTaken[s]  = btbHit[s] && ((ctrlType[s] != fetchPkg::BR_COND) || prediction[s]);
      // returns take their target from the RAS top
      slotTarget[s] = (ctrlType[s] == fetchPkg::BR_RETURN) ? addrRas : btbTarget[s];
      if (slotTaken[s]) begin
        anyTaken  = 1'b1;
        firstSlot = s[fetchPkg::SLOT_WIDTH-1:0];
      end
    end
  end

  // pc only moves on its own when neither stalled nor missing
  assign fetchAdvance = !stall_i && !miss;

  // byte address of the deciding slot; a call returns to the next instruction
  assign slotAddr    = {pcReg[fetchPkg::PC_WIDTH-1:fetchPkg::OFFSET_WIDTH], firstSlot,
                        {fetchPkg::SLOT_LSB{1'b0}}};
  assign rasPushAddr = slotAddr + fetchPkg::INST_BYTES;
  assign rasPush     = fetchAdvance && anyTaken && (ctrlType[firstSlot] == fetchPkg::BR_CALL);
  assign rasPop      = fetchAdvance && anyTaken && (ctrlType[firstSlot] == fetchPkg::BR_RETURN);

  // next pc priority
  always_comb begin
    if (recoverFlag_i) begin
      nextPc = recoverPC_i;
    end else if (flagRecoverEX_i) begin
      nextPc = targetAddrEX_i;
    end else if (flagRecoverID_i) begin
      nextPc = targetAddrID_i;
    end else if (anyTaken) begin
      nextPc = slotTarget[firstSlot];
    end else begin
      nextPc = pcReg + fetchPkg::BUNDLE_BYTES;
    end
  end

  // recovery and EX redirects act even under stall or miss
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (recoverFlag_i || flagRecoverEX_i || fetchAdvance) begin
      pcReg <= nextPc;
    end
  end

  assign pc_o         = pcReg;
  assign miss_o       = miss;
  assign fs1Ready_o   = !miss;
  assign btbHit_o     = btbHit;
  assign prediction_o = prediction;
  assign targetAddr_o = slotTarget;

  // every raised redirect must carry a bundle aligned target
  redirectAligned: assert property (@(posedge clk) disable iff (reset)
    (!recoverFlag_i || (recoverPC_i[fetchPkg::OFFSET_WIDTH-1:0] == '0)) &&
    (!flagRecoverEX_i || (targetAddrEX_i[fetchPkg::OFFSET_WIDTH-1:0] == '0)) &&
    (!flagRecoverID_i || (targetAddrID_i[fetchPkg::OFFSET_WIDTH-1:0] == '0)));

endmodule

`default_nettype wire

//--- include/fetchTbChecks.svh
// compare tasks and error counters for the fetch stage 1 testbench
// include inside the testbench module; fetchPkg must be compiled first
`ifndef FETCH_TB_CHECKS_SVH
`define FETCH_TB_CHECKS_SVH

// totals over the run and for the current test
int    errorCount = 0;
int    checkCount = 0;
int    testErrors = 0;
string testName   = "none";

// an error counts against both the test and the run
task automatic noteError(input string msg);
  errorCount++;
  testErrors++;
  $display("ERROR [%s] %s at %0t", testName, msg, $time);
endtask

task automatic checkAddr(input string what, input logic [fetchPkg::PC_WIDTH-1:0] got,
                         input logic [fetchPkg::PC_WIDTH-1:0] exp);
  checkCount++;
  if (got !== exp) begin
    noteError($sformatf("%s got %h expected %h", what, got, exp));
  end
endtask

task automatic checkBundle(input string what,
                           input logic [fetchPkg::BUNDLE_WIDTH-1:0] got,
                           input logic [fetchPkg::BUNDLE_WIDTH-1:0] exp);
  checkCount++;
  if (got !== exp) begin
    noteError($sformatf("%s got %h expected %h", what, got, exp));
  end
endtask

task automatic checkBit(input string what, input logic got, input logic exp);
  checkCount++;
  if (got !== exp) begin
    noteError($sformatf("%s got %b expected %b", what, got, exp));
  end
endtask

task automatic beginTest(input string name);
  testName   = name;
  testErrors = 0;
endtask

// one line per test
task automatic endTest();
  $display("TEST %s: %s (%0d errors)", testName, (testErrors == 0) ? "PASS" : "FAIL",
           testErrors);
endtask

`endif

//--- verif/fetchStage1Tb.sv
// directed testbench for fetch stage 1; keeps its own models of lines, BTB, counters and RAS
// all test addresses stay below 0x400 so every line has its own cache index
`timescale 1ns/1ns
`default_nettype none

module fetchStage1Tb;

  logic clk = 1'b0;
  logic reset;
  logic stall_i;
  logic recoverFlag_i;
  logic [fetchPkg::PC_WIDTH-1:0] recoverPC_i;
  logic flagRecoverEX_i;
  logic [fetchPkg::PC_WIDTH-1:0] targetAddrEX_i;
  logic flagRecoverID_i;
  logic flagCallID_i;
  logic [fetchPkg::PC_WIDTH-1:0] callPCID_i;
  logic flagRtrID_i;
  logic [fetchPkg::PC_WIDTH-1:0] targetAddrID_i;
  logic updateEn_i;
  logic [fetchPkg::PC_WIDTH-1:0] updatePC_i;
  logic [fetchPkg::PC_WIDTH-1:0] updateTargetAddr_i;
  fetchPkg::brType_e updateBrType_i;
  logic updateDir_i;
  logic wrEnable_i;
  logic [fetchPkg::PC_WIDTH-1:0] wrAddr_i;
  logic [fetchPkg::BUNDLE_WIDTH-1:0] instBlock_i;
  logic [fetchPkg::PC_WIDTH-1:0] pc_o;
  logic [fetchPkg::BUNDLE_WIDTH-1:0] instructionBundle_o;
  logic fs1Ready_o;
  logic miss_o;
  logic [fetchPkg::PC_WIDTH-1:0] missAddr_o;
  logic [fetchPkg::FETCH_WIDTH-1:0] btbHit_o;
  logic [fetchPkg::FETCH_WIDTH-1:0] prediction_o;
  logic [fetchPkg::FETCH_WIDTH-1:0][fetchPkg::PC_WIDTH-1:0] targetAddr_o;

  // reference models
  logic [fetchPkg::BUNDLE_WIDTH-1:0] memLine [fetchPkg::ICACHE_LINES];
  logic btbValid [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];
  logic [fetchPkg::BTB_TAG_WIDTH-1:0] btbTag [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];
  fetchPkg::brType_e btbType [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];
  logic [fetchPkg::PC_WIDTH-1:0] btbTarget [fetchPkg::FETCH_WIDTH][fetchPkg::BTB_ENTRIES];
  logic [1:0] cnt [fetchPkg::FETCH_WIDTH][fetchPkg::BP_ENTRIES];
  logic [fetchPkg::PC_WIDTH-1:0] rasMem [fetchPkg::RAS_DEPTH];
  int rasPtr;
  logic timedOut = 1'b0;

  `include "fetchTbChecks.svh"

  fetchStage1 fetchStage1_i (
    .clk                 (clk),
    .reset               (reset),
    .stall_i             (stall_i),
    .recoverFlag_i       (recoverFlag_i),
    .recoverPC_i         (recoverPC_i),
    .flagRecoverEX_i     (flagRecoverEX_i),
    .targetAddrEX_i      (targetAddrEX_i),
    .flagRecoverID_i     (flagRecoverID_i),
    .flagCallID_i        (flagCallID_i),
    .callPCID_i          (callPCID_i),
    .flagRtrID_i         (flagRtrID_i),
    .targetAddrID_i      (targetAddrID_i),
    .updateEn_i          (updateEn_i),
    .updatePC_i          (updatePC_i),
    .updateTargetAddr_i  (updateTargetAddr_i),
    .updateBrType_i      (updateBrType_i),
    .updateDir_i         (updateDir_i),
    .wrEnable_i          (wrEnable_i),
    .wrAddr_i            (wrAddr_i),
    .instBlock_i         (instBlock_i),
    .pc_o                (pc_o),
    .instructionBundle_o (instructionBundle_o),
    .fs1Ready_o          (fs1Ready_o),
    .miss_o              (miss_o),
    .missAddr_o          (missAddr_o),
    .btbHit_o            (btbHit_o),
    .prediction_o        (prediction_o),
    .targetAddr_o        (targetAddr_o)
  );

  always #5 clk = ~clk;

  task automatic initModels();
    for (int s = 0; s < fetchPkg::FETCH_WIDTH; s++) begin
      for (int e = 0; e < fetchPkg::BTB_ENTRIES; e++) begin
        btbValid[s][e] = 1'b0;
      end
      for (int e = 0; e < fetchPkg::BP_ENTRIES; e++) begin
        cnt[s][e] = fetchPkg::CNT_WEAK_NT;
      end
    end
    for (int i = 0; i < fetchPkg::RAS_DEPTH; i++) begin
      rasMem[i] = '0;
    end
    rasPtr = 0;
  endtask

  // model lookups straight from the address fields
  function automatic logic slotHit(input logic [fetchPkg::PC_WIDTH-1:0] pc, input int s);
    logic [fetchPkg::BTB_INDEX_WIDTH-1:0] idx;
    idx = pc[fetchPkg::OFFSET_WIDTH +: fetchPkg::BTB_INDEX_WIDTH];
    return btbValid[s][idx] && (btbTag[s][idx] == pc[fetchPkg::PC_WIDTH-1 -: fetchPkg::BTB_TAG_WIDTH]);
  endfunction

  function automatic logic slotPredict(input logic [fetchPkg::PC_WIDTH-1:0] pc, input int s);
    return cnt[s][pc[fetchPkg::OFFSET_WIDTH +: fetchPkg::BP_INDEX_WIDTH]] >= fetchPkg::CNT_TAKEN_MIN;
  endfunction

  function automatic fetchPkg::brType_e slotKind(input logic [fetchPkg::PC_WIDTH-1:0] pc,
                                                 input int s);
    return btbType[s][pc[fetchPkg::OFFSET_WIDTH +: fetchPkg::BTB_INDEX_WIDTH]];
  endfunction

  // returns read the RAS top instead of the stored target
  function automatic logic [fetchPkg::PC_WIDTH-1:0] slotTarget(
      input logic [fetchPkg::PC_WIDTH-1:0] pc, input int s);
    if (slotKind(pc, s) == fetchPkg::BR_RETURN) begin
      return rasMem[rasPtr];
    end
    return btbTarget[s][pc[fetchPkg::OFFSET_WIDTH +: fetchPkg::BTB_INDEX_WIDTH]];
  endfunction

  // lowest slot that hits and is taken, -1 for none
  function automatic int firstTaken(input logic [fetchPkg::PC_WIDTH-1:0] pc);
    for (int s = 0; s < fetchPkg::FETCH_WIDTH; s++) begin
      if (slotHit(pc, s) && ((slotKind(pc, s) != fetchPkg::BR_COND) || slotPredict(pc, s))) begin
        return s;
      end
    end
    return -1;
  endfunction

  task automatic rasModelPush(input logic [fetchPkg::PC_WIDTH-1:0] addr);
    rasPtr = (rasPtr + 1) % fetchPkg::RAS_DEPTH;
    rasMem[rasPtr] = addr;
  endtask

  // one line refill with fresh random words
  task automatic refill(input logic [fetchPkg::PC_WIDTH-1:0] addr);
    logic [fetchPkg::ICACHE_INDEX_WIDTH-1:0] idx;
    idx = addr[fetchPkg::OFFSET_WIDTH +: fetchPkg::ICACHE_INDEX_WIDTH];
    memLine[idx] = {$urandom, $urandom, $urandom, $urandom};
    wrEnable_i = 1'b1;
    wrAddr_i = addr;
    instBlock_i = memLine[idx];
    @(negedge clk);
    wrEnable_i = 1'b0;
  endtask

  task automatic waitReady(input int limit);
    int n;
    n = 0;
    while ((fs1Ready_o !== 1'b1) && (n < limit)) begin
      n++;
      @(negedge clk);
    end
    if (fs1Ready_o !== 1'b1) begin
      timedOut = 1'b1;
      noteError($sformatf("fs1Ready_o did not rise within %0d cycles after refill", limit));
    end
  endtask

  // in-order update, models follow the same gating rules
  task automatic train(input logic [fetchPkg::PC_WIDTH-1:0] pc, input fetchPkg::brType_e kind,
                       input logic [fetchPkg::PC_WIDTH-1:0] target, input logic dir);
    int s;
    int bi;
    int pi;
    s = pc[fetchPkg::SLOT_LSB +: fetchPkg::SLOT_WIDTH];
    bi = pc[fetchPkg::OFFSET_WIDTH +: fetchPkg::BTB_INDEX_WIDTH];
    pi = pc[fetchPkg::OFFSET_WIDTH +: fetchPkg::BP_INDEX_WIDTH];
    updateEn_i = 1'b1;
    updatePC_i = pc;
    updateBrType_i = kind;
    updateTargetAddr_i = target;
    updateDir_i = dir;
    @(negedge clk);
    updateEn_i = 1'b0;
    if ((kind != fetchPkg::BR_COND) || dir) begin
      btbValid[s][bi] = 1'b1;
      btbTag[s][bi] = pc[fetchPkg::PC_WIDTH-1 -: fetchPkg::BTB_TAG_WIDTH];
      btbType[s][bi] = kind;
      btbTarget[s][bi] = target;
    end
    if (kind == fetchPkg::BR_COND) begin
      if (dir && (cnt[s][pi] != 2'd3)) begin
        cnt[s][pi] = cnt[s][pi] + 2'd1;
      end else if (!dir && (cnt[s][pi] != 2'd0)) begin
        cnt[s][pi] = cnt[s][pi] - 2'd1;
      end
    end
  endtask

  // park the pc on addr with an EX redirect under stall
  task automatic positionAt(input logic [fetchPkg::PC_WIDTH-1:0] addr);
    stall_i = 1'b1;
    flagRecoverEX_i = 1'b1;
    targetAddrEX_i = addr;
    @(negedge clk);
    flagRecoverEX_i = 1'b0;
    checkAddr("pc_o", pc_o, addr);
  endtask

  // check the lookup of one bundle, then let it fetch for one cycle
  task automatic fetchFrom(input logic [fetchPkg::PC_WIDTH-1:0] addr);
    int s;
    logic [fetchPkg::PC_WIDTH-1:0] expPc;
    logic [fetchPkg::PC_WIDTH-1:0] slotAddr;
    positionAt(addr);
    for (int k = 0; k < fetchPkg::FETCH_WIDTH; k++) begin
      checkBit($sformatf("btbHit_o[%0d]", k), btbHit_o[k], slotHit(addr, k));
      checkBit($sformatf("prediction_o[%0d]", k), prediction_o[k], slotPredict(addr, k));
      if (slotHit(addr, k)) begin
        checkAddr($sformatf("targetAddr_o[%0d]", k), targetAddr_o[k], slotTarget(addr, k));
      end
    end
    s = firstTaken(addr);
    expPc = (s < 0) ? addr + fetchPkg::BUNDLE_BYTES : slotTarget(addr, s);
    stall_i = 1'b0;
    @(negedge clk);
    stall_i = 1'b1;
    checkAddr("pc_o", pc_o, expPc);
    // a taken call or return moves the RAS model
    if (s >= 0) begin
      slotAddr = {addr[fetchPkg::PC_WIDTH-1:fetchPkg::OFFSET_WIDTH], 2'(s), 2'b00};
      if (slotKind(addr, s) == fetchPkg::BR_CALL) begin
        rasModelPush(slotAddr + fetchPkg::INST_BYTES);
      end else if (slotKind(addr, s) == fetchPkg::BR_RETURN) begin
        rasPtr = (rasPtr + fetchPkg::RAS_DEPTH - 1) % fetchPkg::RAS_DEPTH;
      end
    end
  endtask

  task automatic resetRefill();
    logic [fetchPkg::PC_WIDTH-1:0] expPc;
    beginTest("reset and refill");
    checkAddr("pc_o", pc_o, '0);
    checkBit("miss_o", miss_o, 1'b1);
    checkAddr("missAddr_o", missAddr_o, '0);
    checkBit("fs1Ready_o", fs1Ready_o, 1'b0);
    // fill the next lines first, pc stays on the missing line 0
    for (int i = 1; i < 4; i++) begin
      refill(i * 16);
      checkAddr("pc_o", pc_o, '0);
    end
    refill('0);
    waitReady(4);
    expPc = '0;
    for (int i = 0; i < 4; i++) begin
      checkAddr("pc_o", pc_o, expPc);
      checkBit("fs1Ready_o", fs1Ready_o, 1'b1);
      checkBundle("instructionBundle_o", instructionBundle_o,
                  memLine[expPc[fetchPkg::OFFSET_WIDTH +: fetchPkg::ICACHE_INDEX_WIDTH]]);
      expPc = expPc + fetchPkg::BUNDLE_BYTES;
      @(negedge clk);
    end
    // line 0x40 is still absent
    for (int i = 0; i < 3; i++) begin
      checkAddr("pc_o", pc_o, 32'h40);
      checkBit("miss_o", miss_o, 1'b1);
      checkAddr("missAddr_o", missAddr_o, 32'h40);
      @(negedge clk);
    end
    endTest();
  endtask

  task automatic stallHold();
    beginTest("stall");
    stall_i = 1'b1;
    // load the rest of the cache while the pc is frozen
    for (int i = 4; i < fetchPkg::ICACHE_LINES; i++) begin
      refill(i * 16);
      checkAddr("pc_o", pc_o, 32'h40);
    end
    checkBit("fs1Ready_o", fs1Ready_o, 1'b1);
    positionAt(32'h200);
    @(negedge clk);
    checkAddr("pc_o", pc_o, 32'h200);
    stall_i = 1'b0;
    @(negedge clk);
    stall_i = 1'b1;
    checkAddr("pc_o", pc_o, 32'h210);
    endTest();
  endtask

  task automatic jumpCond();
    beginTest("jump and conditional");
    train(32'h088, fetchPkg::BR_JUMP, 32'h300, 1'b1);
    fetchFrom(32'h080);
    // not taken, so only the counter moves
    train(32'h0C4, fetchPkg::BR_COND, 32'h180, 1'b0);
    fetchFrom(32'h0C0);
    for (int i = 0; i < 3; i++) begin
      train(32'h0C4, fetchPkg::BR_COND, 32'h180, 1'b1);
      fetchFrom(32'h0C0);
    end
    endTest();
  endtask

  task automatic callReturn();
    beginTest("call and return");
    train(32'h104, fetchPkg::BR_CALL, 32'h200, 1'b1);
    train(32'h200, fetchPkg::BR_RETURN, 32'h0, 1'b1);
    fetchFrom(32'h100);
    fetchFrom(32'h200);
    // decode correction for a call the BTB missed
    positionAt(32'h340);
    flagRecoverID_i = 1'b1;
    flagCallID_i = 1'b1;
    callPCID_i = 32'h2B0;
    targetAddrID_i = 32'h280;
    stall_i = 1'b0;
    @(negedge clk);
    flagRecoverID_i = 1'b0;
    flagCallID_i = 1'b0;
    stall_i = 1'b1;
    rasModelPush(32'h2B0);
    checkAddr("pc_o", pc_o, 32'h280);
    fetchFrom(32'h200);
    endTest();
  endtask

  task automatic redirectPriority();
    logic [fetchPkg::PC_WIDTH-1:0] expPc;
    beginTest("redirect priority");
    for (int m = 0; m < 8; m++) begin
      positionAt(32'h080);
      recoverFlag_i = m[2];
      recoverPC_i = 32'h040;
      flagRecoverEX_i = m[1];
      targetAddrEX_i = 32'h050;
      flagRecoverID_i = m[0];
      targetAddrID_i = 32'h060;
      stall_i = 1'b0;
      expPc = m[2] ? 32'h040 : m[1] ? 32'h050 : m[0] ? 32'h060 :
              slotTarget(32'h080, firstTaken(32'h080));
      @(negedge clk);
      recoverFlag_i = 1'b0;
      flagRecoverEX_i = 1'b0;
      flagRecoverID_i = 1'b0;
      stall_i = 1'b1;
      checkAddr("pc_o", pc_o, expPc);
    end
    // nothing at all
    fetchFrom(32'h340);
    endTest();
  endtask

  initial begin
    void'($urandom(97));
    initModels();
    reset = 1'b1;
    stall_i = 1'b0;
    recoverFlag_i = 1'b0;
    recoverPC_i = '0;
    flagRecoverEX_i = 1'b0;
    targetAddrEX_i = '0;
    flagRecoverID_i = 1'b0;
    flagCallID_i = 1'b0;
    callPCID_i = '0;
    flagRtrID_i = 1'b0;
    targetAddrID_i = '0;
    updateEn_i = 1'b0;
    updatePC_i = '0;
    updateTargetAddr_i = '0;
    updateBrType_i = fetchPkg::BR_RETURN;
    updateDir_i = 1'b0;
    wrEnable_i = 1'b0;
    wrAddr_i = '0;
    instBlock_i = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    resetRefill();
    if (!timedOut) begin
      stallHold();
      jumpCond();
      callReturn();
      redirectPriority();
    end
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
verilog/fetchPkg.sv
verilog/branchTargetBuffer.sv
verilog/branchPredictor.sv
verilog/returnAddrStack.sv
verilog/instCache.sv
verilog/fetchStage1.sv
verif/fetchStage1Tb.sv
